// ==== logic/bank_mapper.sv ====
`timescale 1ns/100ps
`default_nettype none

module bank_mapper (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [zbus_pkg::addr_w-1:0] a,
    input  logic                        mreq_n,
    input  logic                        iorq_n,
    input  logic                        wr_n,
    input  logic                        bus_write,
    input  logic                        dis_regs,
    input  zbus_pkg::byte_t             wrdata,
    output zbus_pkg::byte_t             bank_rddata,
    output logic                        bank_hit,
    output logic [zbus_pkg::ba_w-1:0]   ba,
    output logic                        ram_ce_n,
    output logic                        cart_ce_n,
    output logic                        ram_we_n
);

    import zbus_pkg::*;

    byte_t bank_r [4];     // IO F0-F3

    ////////////////////////////////////////////////////////////////////////////
    // Bank registers
    ////////////////////////////////////////////////////////////////////////////
    logic sel_io_bank;

    assign sel_io_bank = !dis_regs && !iorq_n && a[7:2] == io_bank_base[7:2];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 4; i++)
                bank_r[i] <= bank_reset[i];
        end else if (sel_io_bank && bus_write) begin
            bank_r[a[1:0]] <= wrdata;
        end
    end

    assign bank_hit    = sel_io_bank;
    assign bank_rddata = bank_r[a[1:0]];

    ////////////////////////////////////////////////////////////////////////////
    // Memory decode
    ////////////////////////////////////////////////////////////////////////////
    byte_t bank;
    page_t bank_page;
    logic  bank_overlay;
    logic  bank_ro;

    assign bank         = bank_r[a[15:14]];    // One register per 16KB quarter
    assign bank_page    = bank[page_w-1:0];
    assign bank_overlay = bank[6];
    assign bank_ro      = bank[7];

    logic sel_mem_sysram;
    logic allow_sel_mem;
    logic sel_mem_cart;
    logic sel_mem_ram;

    // 3800-3FFF within the bank
    assign sel_mem_sysram = !mreq_n && bank_overlay && a[13:11] == overlay_sel;

    // Writes to a read-only bank select nothing
    assign allow_sel_mem = !mreq_n && !sel_mem_sysram && (wr_n || !bank_ro);

    assign sel_mem_cart = allow_sel_mem && bank_page >= page_cart_lo
                          && bank_page <= page_cart_hi;
    assign sel_mem_ram  = (allow_sel_mem && bank_page >= page_ram_lo) || sel_mem_sysram;

    assign ram_we_n  = !(!wr_n && (sel_mem_sysram || (sel_mem_ram && !bank_ro)));
    assign ram_ce_n  = !sel_mem_ram;
    assign cart_ce_n = !sel_mem_cart;

    // Sysram sits in page 32, which is bank 0 of the RAM chip
    assign ba = sel_mem_sysram ? '0 : bank_page[ba_w-1:0];

    a_one_chip_enable: assert property (@(posedge clk) disable iff (reset)
        !(!ram_ce_n && !cart_ce_n));

endmodule

`default_nettype wire

// ==== logic/bus_strobe_sync.sv ====
`timescale 1ns/100ps
`default_nettype none

module bus_strobe_sync (
    input  logic            clk,
    input  logic            reset,
    input  logic            rd_n,
    input  logic            wr_n,
    input  zbus_pkg::byte_t d_in,
    output logic            bus_read,
    output logic            bus_write,
    output zbus_pkg::byte_t wrdata
);

    logic [2:0] rd_n_r;
    logic [2:0] wr_n_r;

    // Strobes idle high, so the chains come out of reset as ones
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_n_r <= 3'b111;
            wr_n_r <= 3'b111;
        end else begin
            rd_n_r <= {rd_n_r[1:0], rd_n};
            wr_n_r <= {wr_n_r[1:0], wr_n};
        end
    end

    // Falling edge seen between stage 1 and stage 2
    assign bus_read  = rd_n_r[2:1] == 2'b10;
    assign bus_write = wr_n_r[2:1] == 2'b10;

    // Last value on the bus before wr_n rises
    always_ff @(posedge clk) begin
        if (!wr_n)
            wrdata <= d_in;
    end

    // The Z80 never asserts both strobes in one cycle
    a_no_rd_wr_overlap: assert property (@(posedge clk) disable iff (reset)
        !(bus_read && bus_write));

endmodule

`default_nettype wire

// ==== logic/io_port_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module io_port_decoder (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [zbus_pkg::addr_w-1:0] a,
    input  logic                        iorq_n,
    input  logic                        rd_n,
    input  logic                        bus_read,
    input  logic                        bus_write,
    input  zbus_pkg::byte_t             wrdata,
    input  zbus_pkg::byte_t             bank_rddata,
    input  logic                        bank_hit,
    input  logic [63:0]                 keys,
    input  logic                        cassette_in,
    input  logic                        printer_in,
    input  logic                        kb_push,
    input  zbus_pkg::byte_t             kb_push_data,
    output logic                        dis_regs,
    output logic                        cassette_out,
    output logic                        printer_out,
    output logic                        cpm_remap,
    output zbus_pkg::byte_t             d_out,
    output logic                        d_oe
);

    import zbus_pkg::*;

    logic sel_kbbuf;
    logic sel_sysctrl;
    logic sel_cassette;
    logic sel_cpm;
    logic sel_printer;
    logic sel_keyb;

    assign sel_kbbuf    = !iorq_n && a[7:0] == io_kbbuf;
    assign sel_sysctrl  = !iorq_n && a[7:0] == io_sysctrl;
    assign sel_cassette = !iorq_n && a[7:0] == io_cassette;
    assign sel_cpm      = !iorq_n && a[7:0] == io_cpm;
    assign sel_printer  = !iorq_n && a[7:0] == io_printer;
    assign sel_keyb     = !iorq_n && a[7:0] == io_keyb;

    ////////////////////////////////////////////////////////////////////////////
    // Control registers and input synchronizers
    ////////////////////////////////////////////////////////////////////////////
    logic       turbo_r;
    logic       dis_psgs_r;
    logic [2:0] cassette_in_r;
    logic [2:0] printer_in_r;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            {turbo_r, dis_psgs_r, dis_regs} <= 3'b000;
            cassette_out <= 1'b0;
            printer_out  <= 1'b0;
            cpm_remap    <= 1'b0;
        end else if (bus_write) begin
            if (sel_sysctrl)  {turbo_r, dis_psgs_r, dis_regs} <= wrdata[2:0];
            if (sel_cassette) cassette_out <= wrdata[0];
            if (sel_printer)  printer_out  <= wrdata[0];
            if (sel_cpm)      cpm_remap    <= wrdata[0];
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cassette_in_r <= '0;
            printer_in_r  <= '0;
        end else begin
            cassette_in_r <= {cassette_in_r[1:0], cassette_in};
            printer_in_r  <= {printer_in_r[1:0], printer_in};
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Keyboard matrix and buffer
    ////////////////////////////////////////////////////////////////////////////
    byte_t kb_byte;

    // A low address bit among a[15:8] enables that row
    always_comb begin
        kb_byte = 8'hFF;
        for (int row = 0; row < 8; row++) begin
            if (!a[8+row])
                kb_byte = kb_byte & keys[8*row +: 8];
        end
    end

    byte_t kb_head;

    key_fifo key_fifo (
        .clk       (clk),
        .reset     (reset),
        .clear     (sel_kbbuf && bus_write),   // Any write to FA flushes
        .push      (kb_push),
        .pop       (sel_kbbuf && bus_read),
        .push_data (kb_push_data),
        .head      (kb_head)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Read mux
    ////////////////////////////////////////////////////////////////////////////
    byte_t rddata;
    logic  sel_local_rd;

    // FD is write-only and never drives the bus
    assign sel_local_rd = sel_kbbuf | sel_sysctrl | sel_cassette | sel_printer | sel_keyb;

    always_comb begin
        rddata = '0;
        if (bank_hit)     rddata = bank_rddata;                                 // F0-F3
        if (sel_kbbuf)    rddata = kb_head;
        if (sel_sysctrl)  rddata = {5'b0, turbo_r, dis_psgs_r, dis_regs};
        if (sel_cassette) rddata = {7'b0, !cassette_in_r[2]};
        if (sel_printer)  rddata = {7'b0, printer_in_r[2]};
        if (sel_keyb)     rddata = kb_byte;
    end

    assign d_oe  = !rd_n && (bank_hit || sel_local_rd);
    assign d_out = rddata;

endmodule

`default_nettype wire

// ==== logic/key_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none

module key_fifo #(
    parameter int depth = zbus_pkg::kbbuf_depth    // Power of two
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            clear,
    input  logic            push,
    input  logic            pop,
    input  zbus_pkg::byte_t push_data,
    output zbus_pkg::byte_t head
);

    import zbus_pkg::*;

    localparam int ptr_w = $clog2(depth);

    byte_t            mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w:0]   count;

    logic full;
    logic empty;
    logic do_push;
    logic do_pop;

    assign full  = count == (ptr_w+1)'(depth);
    assign empty = count == '0;

    // Clear wins over anything else this cycle
    assign do_push = push && !full && !clear;
    assign do_pop  = pop && !empty && !clear;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (clear) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push)
            mem[wr_ptr] <= push_data;
    end

    assign head = empty ? '0 : mem[rd_ptr];    // Reads 00 when empty

    // Occupancy stays within depth and agrees with the pointer distance
    a_count_bound: assert property (@(posedge clk) disable iff (reset)
        count <= (ptr_w+1)'(depth) && count[ptr_w-1:0] == wr_ptr - rd_ptr);

endmodule

`default_nettype wire

// ==== logic/zbus_glue_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module zbus_glue_top (
    input  logic                        clk,
    input  logic                        reset,

    // Z80 bus
    input  logic [zbus_pkg::addr_w-1:0] a,
    input  zbus_pkg::byte_t             d_in,
    output zbus_pkg::byte_t             d_out,
    output logic                        d_oe,
    input  logic                        rd_n,
    input  logic                        wr_n,
    input  logic                        mreq_n,
    input  logic                        iorq_n,

    // External memory
    output logic [zbus_pkg::ba_w-1:0]   ba,
    output logic                        ram_ce_n,     // 512KB RAM
    output logic                        cart_ce_n,
    output logic                        ram_we_n,

    // Keyboard matrix and buffer filler
    input  logic [63:0]                 keys,
    input  zbus_pkg::byte_t             kb_push_data,
    input  logic                        kb_push,

    input  logic                        cassette_in,
    input  logic                        printer_in,
    output logic                        cassette_out,
    output logic                        printer_out,
    output logic                        cpm_remap
);

    import zbus_pkg::*;

    logic  bus_read;
    logic  bus_write;
    byte_t wrdata;
    logic  dis_regs;
    byte_t bank_rddata;
    logic  bank_hit;

    bus_strobe_sync bus_strobe_sync (
        .clk       (clk),
        .reset     (reset),
        .rd_n      (rd_n),
        .wr_n      (wr_n),
        .d_in      (d_in),
        .bus_read  (bus_read),
        .bus_write (bus_write),
        .wrdata    (wrdata)
    );

    bank_mapper bank_mapper (
        .clk         (clk),
        .reset       (reset),
        .a           (a),
        .mreq_n      (mreq_n),
        .iorq_n      (iorq_n),
        .wr_n        (wr_n),
        .bus_write   (bus_write),
        .dis_regs    (dis_regs),
        .wrdata      (wrdata),
        .bank_rddata (bank_rddata),
        .bank_hit    (bank_hit),
        .ba          (ba),
        .ram_ce_n    (ram_ce_n),
        .cart_ce_n   (cart_ce_n),
        .ram_we_n    (ram_we_n)
    );

    io_port_decoder io_port_decoder (
        .clk          (clk),
        .reset        (reset),
        .a            (a),
        .iorq_n       (iorq_n),
        .rd_n         (rd_n),
        .bus_read     (bus_read),
        .bus_write    (bus_write),
        .wrdata       (wrdata),
        .bank_rddata  (bank_rddata),
        .bank_hit     (bank_hit),
        .keys         (keys),
        .cassette_in  (cassette_in),
        .printer_in   (printer_in),
        .kb_push      (kb_push),
        .kb_push_data (kb_push_data),
        .dis_regs     (dis_regs),
        .cassette_out (cassette_out),
        .printer_out  (printer_out),
        .cpm_remap    (cpm_remap),
        .d_out        (d_out),
        .d_oe         (d_oe)
    );

endmodule

`default_nettype wire

// ==== logic/zbus_pkg.sv ====
`default_nettype none

package zbus_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Bus widths and types
    ////////////////////////////////////////////////////////////////////////////
    localparam int addr_w = 16;
    localparam int data_w = 8;
    localparam int page_w = 6;
    localparam int ba_w   = 5;     // External bank address for 512KB in 16KB pages

    typedef logic [data_w-1:0] byte_t;
    typedef logic [page_w-1:0] page_t;

    ////////////////////////////////////////////////////////////////////////////
    // IO port map
    ////////////////////////////////////////////////////////////////////////////
    localparam byte_t io_bank_base = 8'hF0;    // F0-F3
    localparam byte_t io_kbbuf     = 8'hFA;
    localparam byte_t io_sysctrl   = 8'hFB;
    localparam byte_t io_cassette  = 8'hFC;
    localparam byte_t io_cpm       = 8'hFD;    // Write only
    localparam byte_t io_printer   = 8'hFE;
    localparam byte_t io_keyb      = 8'hFF;

    // Memory pages
    localparam page_t page_cart_lo = 6'd16;
    localparam page_t page_cart_hi = 6'd19;
    localparam page_t page_ram_lo  = 6'd32;    // 32-63 all RAM

    // a[13:11] pattern of the sysram window 3800-3FFF
    localparam logic [2:0] overlay_sel = 3'b111;

    // Bank registers after reset with index 0 in the low byte
    // Bank 0 has overlay and read-only set
    localparam byte_t [3:0] bank_reset = {8'h13, 8'h22, 8'h21, 8'hC0};

    localparam int kbbuf_depth = 16;

endpackage

`default_nettype wire

// ==== project.f ====
logic/zbus_pkg.sv
logic/bus_strobe_sync.sv
logic/bank_mapper.sv
logic/key_fifo.sv
logic/io_port_decoder.sv
logic/zbus_glue_top.sv
sim/tb_clock.sv
sim/tb_zbus_glue.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator and run it
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_zbus_glue -f project.f -o tb_zbus_glue
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_zbus_glue)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qxF '*** PASSED ***' <<< "$output"; then
    exit 0
else
    exit 1
fi

// ==== sim/tb_clock.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clock #(
    parameter int period       = 40,
    parameter int reset_cycles = 3
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(negedge clk);    // Released on a falling edge
        reset = 1'b0;
    end

endmodule

`default_nettype wire

// ==== sim/tb_zbus_glue.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_zbus_glue;

    import zbus_pkg::*;

    localparam int strobe_len = 8;
    localparam int bus_cycles = 90;          // Rough total over all tests
    localparam int max_cycles = bus_cycles * (strobe_len + 3) * 4;

    // Bank registers after reset with F0 in the low byte
    localparam logic [31:0] reset_banks = 32'h13_22_21_C0;

    logic              clk;
    logic              reset;
    logic [addr_w-1:0] a;
    byte_t             d_in;
    byte_t             d_out;
    logic              d_oe;
    logic              rd_n;
    logic              wr_n;
    logic              mreq_n;
    logic              iorq_n;
    logic [ba_w-1:0]   ba;
    logic              ram_ce_n;
    logic              cart_ce_n;
    logic              ram_we_n;
    logic [63:0]       keys;
    byte_t             kb_push_data;
    logic              kb_push;
    logic              cassette_in;
    logic              printer_in;
    logic              cassette_out;
    logic              printer_out;
    logic              cpm_remap;

    // Outputs captured one cycle into the strobe
    byte_t             s_d_out;
    logic              s_d_oe;
    logic              s_ram_ce_n;
    logic              s_cart_ce_n;
    logic              s_ram_we_n;
    logic [ba_w-1:0]   s_ba;

    int errors;
    int tests_failed;
    int cycles = 0;

    tb_clock #(.period(40), .reset_cycles(3)) clock_gen (.clk(clk), .reset(reset));

    zbus_glue_top uut (
        .clk          (clk),
        .reset        (reset),
        .a            (a),
        .d_in         (d_in),
        .d_out        (d_out),
        .d_oe         (d_oe),
        .rd_n         (rd_n),
        .wr_n         (wr_n),
        .mreq_n       (mreq_n),
        .iorq_n       (iorq_n),
        .ba           (ba),
        .ram_ce_n     (ram_ce_n),
        .cart_ce_n    (cart_ce_n),
        .ram_we_n     (ram_we_n),
        .keys         (keys),
        .kb_push_data (kb_push_data),
        .kb_push      (kb_push),
        .cassette_in  (cassette_in),
        .printer_in   (printer_in),
        .cassette_out (cassette_out),
        .printer_out  (printer_out),
        .cpm_remap    (cpm_remap)
    );

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("Timeout after %0d cycles, the tests did not complete", cycles);
            $display("*** FAILED ***");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks and bus cycles
    ////////////////////////////////////////////////////////////////////////////
    task automatic check_byte(input string name, input byte_t got, input byte_t exp);
        assert (got === exp) else begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        assert (got === exp) else begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int errors_at_start);
        if (errors == errors_at_start) begin
            $display("test %-14s ok", name);
        end else begin
            tests_failed++;
            $display("test %-14s %0d errors", name, errors - errors_at_start);
        end
    endtask

    // Address first, strobe low for strobe_len cycles, then release
    task automatic bus_cycle(input logic [15:0] addr, input logic is_io,
                             input logic is_write, input byte_t data);
        @(negedge clk);
        a    = addr;
        d_in = data;
        if (is_io) iorq_n = 1'b0;
        else       mreq_n = 1'b0;
        @(negedge clk);
        if (is_write) wr_n = 1'b0;
        else          rd_n = 1'b0;
        @(negedge clk);
        s_d_out     = d_out;           // Before bus_read can pop the FIFO
        s_d_oe      = d_oe;
        s_ram_ce_n  = ram_ce_n;
        s_cart_ce_n = cart_ce_n;
        s_ram_we_n  = ram_we_n;
        s_ba        = ba;
        repeat (strobe_len - 1) @(negedge clk);
        wr_n = 1'b1;
        rd_n = 1'b1;
        @(negedge clk);
        iorq_n = 1'b1;
        mreq_n = 1'b1;
    endtask

    task automatic io_write(input logic [15:0] port, input byte_t data);
        bus_cycle(port, 1'b1, 1'b1, data);
    endtask

    task automatic io_read(input logic [15:0] port);
        bus_cycle(port, 1'b1, 1'b0, 8'h00);
    endtask

    task automatic mem_access(input logic [15:0] addr, input logic is_write, input byte_t data);
        bus_cycle(addr, 1'b0, is_write, data);
    endtask

    task automatic expect_read(input logic [15:0] port, input byte_t exp);
        io_read(port);
        check_bit("d_oe", s_d_oe, 1'b1);
        check_byte("d_out", s_d_out, exp);
    endtask

    task automatic push_key(input byte_t data);
        @(negedge clk);
        kb_push_data = data;
        kb_push      = 1'b1;
        @(negedge clk);
        kb_push      = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////////////////////
    task automatic test_reset_values;
        int start;
        start = errors;
        for (int i = 0; i < 4; i++)
            expect_read(16'h00F0 + 16'(i), reset_banks[8*i +: 8]);
        io_read(16'h0010);                       // Unused port
        check_bit("d_oe", s_d_oe, 1'b0);
        finish_test("reset_values", start);
    endtask

    task automatic test_bank_mapping;
        int    start;
        page_t page;
        logic  exp_ram;
        logic  exp_cart;
        start = errors;
        for (int i = 0; i < 10; i++) begin
            if (i == 0)      page = 6'd18;
            else if (i == 1) page = 6'd45;
            else             page = 6'($urandom);
            io_write(16'h00F1, {2'b00, page});
            mem_access({2'b01, 14'($urandom)}, 1'b0, 8'h00);
            exp_ram  = page >= 6'd32;
            exp_cart = page >= 6'd16 && page <= 6'd19;
            check_bit("ram_ce_n", s_ram_ce_n, !exp_ram);
            check_bit("cart_ce_n", s_cart_ce_n, !exp_cart);
            check_byte("ba", {3'b000, s_ba}, {3'b000, page[4:0]});
        end
        io_write(16'h00F1, 8'h21);
        // Sysram window through bank 0
        mem_access({5'b00111, 11'($urandom)}, 1'b0, 8'h00);
        check_bit("ram_ce_n", s_ram_ce_n, 1'b0);
        check_bit("cart_ce_n", s_cart_ce_n, 1'b1);
        check_byte("ba", {3'b000, s_ba}, 8'h00);
        mem_access(16'h0100, 1'b0, 8'h00);       // Page 0 selects nothing external
        check_bit("ram_ce_n", s_ram_ce_n, 1'b1);
        check_bit("cart_ce_n", s_cart_ce_n, 1'b1);
        mem_access({2'b11, 14'($urandom)}, 1'b0, 8'h00);    // Cart page 19
        check_bit("cart_ce_n", s_cart_ce_n, 1'b0);
        check_bit("ram_ce_n", s_ram_ce_n, 1'b1);
        check_byte("ba", {3'b000, s_ba}, 8'd19);
        finish_test("bank_mapping", start);
    endtask

    task automatic test_read_only;
        int          start;
        logic [15:0] addr;
        start = errors;
        addr  = {2'b10, 14'($urandom)};
        io_write(16'h00F2, 8'hA8);               // Read-only page 40
        mem_access(addr, 1'b1, 8'h5A);
        check_bit("ram_ce_n", s_ram_ce_n, 1'b1);
        check_bit("ram_we_n", s_ram_we_n, 1'b1);
        check_bit("cart_ce_n", s_cart_ce_n, 1'b1);
        mem_access(addr, 1'b0, 8'h00);
        check_bit("ram_ce_n", s_ram_ce_n, 1'b0);
        check_bit("ram_we_n", s_ram_we_n, 1'b1);
        io_write(16'h00F2, 8'h28);
        mem_access(addr, 1'b1, 8'h5A);
        check_bit("ram_ce_n", s_ram_ce_n, 1'b0);
        check_bit("ram_we_n", s_ram_we_n, 1'b0);
        io_write(16'h00F2, 8'h22);
        finish_test("read_only", start);
    endtask

    task automatic test_sys_control;
        int start;
        start = errors;
        io_write(16'h00FB, 8'h01);
        io_read(16'h00F0);
        check_bit("d_oe", s_d_oe, 1'b0);
        io_write(16'h00F0, 8'h55);               // Must not land
        expect_read(16'h00FB, 8'h01);
        io_write(16'h00FB, 8'h00);
        expect_read(16'h00F0, 8'hC0);
        io_write(16'h00FB, 8'h06);               // Turbo and dis_psgs only
        expect_read(16'h00FB, 8'h06);
        expect_read(16'h00F0, 8'hC0);            // Bank ports stay enabled
        io_write(16'h00FB, 8'h00);
        finish_test("sys_control", start);
    endtask

    task automatic test_ports;
        int          start;
        logic [7:0]  row_sel;
        byte_t       kb_exp;
        start = errors;
        io_write(16'h00FC, 8'h01);
        io_write(16'h00FE, 8'h01);
        io_write(16'h00FD, 8'h01);
        check_bit("cassette_out", cassette_out, 1'b1);
        check_bit("printer_out", printer_out, 1'b1);
        check_bit("cpm_remap", cpm_remap, 1'b1);
        io_write(16'h00FC, 8'h00);
        io_write(16'h00FE, 8'h00);
        io_write(16'h00FD, 8'h00);
        check_bit("cassette_out", cassette_out, 1'b0);
        check_bit("printer_out", printer_out, 1'b0);
        check_bit("cpm_remap", cpm_remap, 1'b0);

        cassette_in = 1'b1;
        printer_in  = 1'b0;
        repeat (4) @(negedge clk);               // Through the synchronizers
        expect_read(16'h00FC, 8'h00);
        expect_read(16'h00FE, 8'h00);
        cassette_in = 1'b0;
        printer_in  = 1'b1;
        repeat (4) @(negedge clk);
        expect_read(16'h00FC, 8'h01);
        expect_read(16'h00FE, 8'h01);

        // Low bits of the high address byte pick the rows
        for (int i = 0; i < 4; i++) begin
            keys    = {$urandom, $urandom};
            row_sel = 8'($urandom);
            kb_exp  = 8'hFF;
            for (int row = 0; row < 8; row++) begin
                if (!row_sel[row])
                    kb_exp = kb_exp & keys[8*row +: 8];
            end
            expect_read({row_sel, 8'hFF}, kb_exp);
        end
        finish_test("ports", start);
    endtask

    task automatic test_key_fifo;
        int    start;
        byte_t sent [$];
        byte_t val;
        start = errors;
        for (int i = 0; i < 5; i++) begin
            val = 8'($urandom);
            sent.push_back(val);
            push_key(val);
        end
        for (int i = 0; i < 5; i++)
            expect_read(16'h00FA, sent[i]);
        expect_read(16'h00FA, 8'h00);            // Empty now

        for (int i = 0; i < 3; i++)
            push_key(8'($urandom));
        io_write(16'h00FA, 8'h00);               // Flush
        expect_read(16'h00FA, 8'h00);

        // Only the first 16 of 20 are kept
        sent.delete();
        for (int i = 0; i < 20; i++) begin
            val = 8'($urandom);
            sent.push_back(val);
            push_key(val);
        end
        for (int i = 0; i < 16; i++)
            expect_read(16'h00FA, sent[i]);
        expect_read(16'h00FA, 8'h00);
        finish_test("key_fifo", start);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        void'($urandom(88622));
        a            = '0;
        d_in         = 8'h00;
        rd_n         = 1'b1;
        wr_n         = 1'b1;
        mreq_n       = 1'b1;
        iorq_n       = 1'b1;
        keys         = '0;
        kb_push_data = 8'h00;
        kb_push      = 1'b0;
        cassette_in  = 1'b0;
        printer_in   = 1'b0;
        errors       = 0;
        tests_failed = 0;

        wait (reset === 1'b1);
        wait (reset === 1'b0);
        @(negedge clk);

        test_reset_values();
        test_bank_mapping();
        test_read_only();
        test_sys_control();
        test_ports();
        test_key_fifo();

        $display("6 tests run, %0d failed, %0d check errors", tests_failed, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
